// File: all.f
hdl/dac_types_pkg.sv
hdl/dac_timing_pkg.sv
hdl/interp_halfband_2x.sv
hdl/sample_fifo.sv
hdl/interp_sequencer.sv
hdl/sigma_delta_2nd.sv
hdl/stereo_dac_output.sv
dv/tb_stereo_dac_output.sv

// File: dv/tb_stereo_dac_output.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stereo_dac_output;
    import dac_types_pkg::*;
    import dac_timing_pkg::*;

    localparam int IN_PERIOD  = 4 * CLK_DIV_OUT;
    localparam int N_INPUTS   = 300;
    localparam int SETTLE     = 1024;
    localparam int WINDOW     = 4096;
    localparam int TOLERANCE  = 8;
    localparam int WAIT_LIMIT = 256;

    // Same names as the DUT ports so reset is the clock and clk the reset
    logic    reset;
    logic    clk;
    logic    sample_in_rdy;
    stereo_t sample_in;
    logic    dout_l;
    logic    dout_r;

    int          n_tests;
    int          n_errors;
    int          test_errors;
    logic [31:0] rng_state;

    stereo_dac_output u_stereo_dac_output (
        .reset         (reset),
        .clk           (clk),
        .sample_in_rdy (sample_in_rdy),
        .sample_in     (sample_in),
        .dout_l        (dout_l),
        .dout_r        (dout_r)
    );

    initial begin
        reset = 1'b1;
        forever #2 reset = ~reset;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Roughly 0.6 of full scale either way
    function automatic sample_t random_level();
        rng_state = xorshift32(rng_state);
        return sample_t'(int'(rng_state % 32'd157287) - 78643);
    endfunction

    // Ones over the window for a DC input x
    function automatic int expected_ones(sample_t x);
        return (int'(x) + 131072) * WINDOW / 262144;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_density(string name, int expected, int actual);
        if (actual < expected - TOLERANCE || actual > expected + TOLERANCE) begin
            $display("Mismatch in %s: expected %0d ones, actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic end_test(string name);
        n_tests++;
        n_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed (%0d errors)", name, test_errors);
        end
        test_errors = 0;
    endtask

    // One paced input per period with optional extra strobes after it
    task automatic drive_level(string name, sample_t lvl_l, sample_t lvl_r,
                               bit add_drops, sample_t drop_val);
        int cyc;
        int ones_l;
        int ones_r;
        cyc    = 0;
        ones_l = 0;
        ones_r = 0;
        for (int n = 0; n < N_INPUTS; n++) begin
            for (int slot = 0; slot < IN_PERIOD; slot++) begin
                @(negedge reset);
                if (cyc >= SETTLE && cyc < SETTLE + WINDOW) begin
                    ones_l += int'(dout_l);
                    ones_r += int'(dout_r);
                end
                cyc++;
                sample_in_rdy = (slot == 0) || (add_drops && slot <= 3);
                if (slot == 0) begin
                    sample_in.l = lvl_l;
                    sample_in.r = lvl_r;
                end else begin
                    sample_in.l = drop_val;
                    sample_in.r = drop_val;
                end
            end
        end
        check_density({name, " left"}, expected_ones(lvl_l), ones_l);
        check_density({name, " right"}, expected_ones(lvl_r), ones_r);
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic test_reset();
        repeat (5) begin
            @(negedge reset);
            check_bit("reset dout_l", 1'b0, dout_l);
            check_bit("reset dout_r", 1'b0, dout_r);
        end
        clk = 1'b0;
        // Nothing queued yet so the modulator stays idle
        repeat (16) begin
            @(negedge reset);
            check_bit("idle dout_l", 1'b0, dout_l);
            check_bit("idle dout_r", 1'b0, dout_r);
        end
        end_test("reset");
    endtask

    task automatic test_silence();
        int waited;
        @(negedge reset);
        sample_in_rdy = 1'b1;
        sample_in     = '0;
        @(negedge reset);
        sample_in_rdy = 1'b0;
        waited        = 0;
        while (!(dout_l && dout_r) && waited < WAIT_LIMIT) begin
            @(negedge reset);
            waited++;
        end
        if (!(dout_l && dout_r)) begin
            $display("Timeout: the outputs never went high after the first sample");
            test_errors++;
        end
        drive_level("silence", '0, '0, 1'b0, '0);
        end_test("silence");
    endtask

    task automatic test_constant_levels();
        sample_t lvl;
        drive_level("near full scale", 18'sd91750, 18'sd91750, 1'b0, '0);
        drive_level("negative half", -18'sd65536, -18'sd65536, 1'b0, '0);
        drive_level("negative near full", -18'sd91750, -18'sd91750, 1'b0, '0);
        for (int i = 0; i < 4; i++) begin
            lvl = random_level();
            drive_level($sformatf("random level %0d", i), lvl, lvl, 1'b0, '0);
        end
        end_test("constant levels");
    endtask

    task automatic test_channel_independence();
        sample_t lvl_l;
        sample_t lvl_r;
        lvl_l = random_level();
        lvl_r = random_level();
        drive_level("channel independence", lvl_l, lvl_r, 1'b0, '0);
        end_test("channel independence");
    endtask

    task automatic test_step();
        drive_level("step low", -18'sd50000, -18'sd50000, 1'b0, '0);
        drive_level("step high", 18'sd70000, 18'sd70000, 1'b0, '0);
        end_test("step");
    endtask

    task automatic test_dropped_input();
        drive_level("dropped input", 18'sd30000, 18'sd30000, 1'b1, -18'sd100000);
        end_test("dropped input");
    endtask

    initial begin
        clk           = 1'b1;
        sample_in_rdy = 1'b0;
        sample_in     = '0;
        n_tests       = 0;
        n_errors      = 0;
        test_errors   = 0;
        rng_state     = 32'h6553;
        test_reset();
        test_silence();
        test_constant_levels();
        test_channel_independence();
        test_step();
        test_dropped_input();
        $display("Tests run: %0d, errors: %0d", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/dac_timing_pkg.sv
`default_nettype none

package dac_timing_pkg;

    // ------------------------------------------------------------
    // Rates and buffering
    // ------------------------------------------------------------
    localparam int CLK_DIV_OUT    = 16;
    localparam int FIFO_MID_DEPTH = 2;
    localparam int FIFO_OUT_DEPTH = 8;

    // Output FIFO room needed for one burst of the second stage
    localparam int OUT_FREE_MIN = 2;

    typedef logic [$clog2(CLK_DIV_OUT)-1:0]      div_cnt_t;
    typedef logic [$clog2(FIFO_OUT_DEPTH+1)-1:0] out_free_t;

    // Sequencer operations
    typedef enum logic [2:0] {
        OP_WAIT_IN,
        OP_WAIT_DONE,
        OP_SEND_MID,
        OP_JUMP,
        OP_NOP
    } seq_op_e;

endpackage

`default_nettype wire

// File: hdl/dac_types_pkg.sv
`default_nettype none

package dac_types_pkg;

    // ------------------------------------------------------------
    // Audio data path types
    // ------------------------------------------------------------
    typedef logic signed [17:0] sample_t;

    // Interpolator sums and modulator integrators
    typedef logic signed [23:0] acc_t;

    typedef struct packed {
        sample_t l;
        sample_t r;
    } stereo_t;

    // Saturation limits of an 18-bit sample
    localparam sample_t SAMPLE_MAX = 18'sh1ffff;
    localparam sample_t SAMPLE_MIN = {1'b1, {17{1'b0}}};

    // Modulator feedback level, one half of the 18-bit range
    localparam acc_t SD_FULL_SCALE = 24'sd131072;

endpackage

`default_nettype wire

// File: hdl/interp_halfband_2x.sv
`timescale 1ns/1ps
`default_nettype none

module interp_halfband_2x (
    input  logic                   reset,
    input  logic                   clk,
    input  logic                   sample_in_rdy,
    input  dac_types_pkg::stereo_t sample_in,
    output logic                   sample_out_rdy,
    output dac_types_pkg::stereo_t sample_out,
    output logic                   done
);
    import dac_types_pkg::*;

    // Newest first
    stereo_t hist0;
    stereo_t hist1;
    stereo_t hist2;

    stereo_t even_q;
    stereo_t odd_q;
    logic    even_vld;
    logic    odd_vld;

    // (9*(near_a + near_b) - (outer_a + outer_b)) / 16, rounded
    function automatic sample_t halfband_mid(sample_t outer_a, sample_t near_a,
                                             sample_t near_b, sample_t outer_b);
        acc_t near_sum;
        acc_t outer_sum;
        acc_t acc;
        acc_t scaled;
        near_sum  = acc_t'(near_a) + acc_t'(near_b);
        outer_sum = acc_t'(outer_a) + acc_t'(outer_b);
        acc       = (near_sum <<< 3) + near_sum - outer_sum + acc_t'(8);
        scaled    = acc >>> 4;
        if (scaled > acc_t'(SAMPLE_MAX)) begin
            return SAMPLE_MAX;
        end
        if (scaled < acc_t'(SAMPLE_MIN)) begin
            return SAMPLE_MIN;
        end
        return sample_t'(scaled);
    endfunction

    // ------------------------------------------------------------
    // History and output phase
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            hist0    <= '0;
            hist1    <= '0;
            hist2    <= '0;
            even_vld <= 1'b0;
            odd_vld  <= 1'b0;
        end else begin
            even_vld <= sample_in_rdy;
            odd_vld  <= even_vld;
            if (sample_in_rdy) begin
                hist0 <= sample_in;
                hist1 <= hist0;
                hist2 <= hist1;
            end
        end
    end

    // Centre sample, then the midpoint between hist1 and hist0
    always_ff @(posedge reset) begin
        if (sample_in_rdy) begin
            even_q   <= hist1;
            odd_q.l  <= halfband_mid(sample_in.l, hist0.l, hist1.l, hist2.l);
            odd_q.r  <= halfband_mid(sample_in.r, hist0.r, hist1.r, hist2.r);
        end
    end

    assign sample_out_rdy = even_vld | odd_vld;
    assign sample_out     = even_vld ? even_q : odd_q;
    assign done           = odd_vld;

endmodule

`default_nettype wire

// File: hdl/interp_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module interp_sequencer (
    input  logic                      reset,
    input  logic                      clk,
    input  logic                      sample_in_rdy,
    input  logic                      done,
    input  dac_timing_pkg::out_free_t out_free,
    output logic                      accept,
    output logic                      send_mid
);
    import dac_timing_pkg::*;

    logic [2:0] pc;
    seq_op_e    op;
    logic       can_send;

    // ------------------------------------------------------------
    // Program
    // ------------------------------------------------------------
    always_comb begin
        case (pc)
            3'd0:    op = OP_WAIT_IN;
            3'd1:    op = OP_WAIT_DONE;
            3'd2:    op = OP_SEND_MID;
            3'd3:    op = OP_WAIT_DONE;
            3'd4:    op = OP_SEND_MID;
            3'd5:    op = OP_WAIT_DONE;
            3'd6:    op = OP_JUMP;
            default: op = OP_NOP;
        endcase
    end

    // Room for both outputs of the second stage
    assign can_send = (out_free >= out_free_t'(OUT_FREE_MIN));

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc <= '0;
        end else begin
            case (op)
                OP_WAIT_IN: begin
                    if (sample_in_rdy) begin
                        pc <= pc + 3'd1;
                    end
                end
                OP_WAIT_DONE: begin
                    if (done) begin
                        pc <= pc + 3'd1;
                    end
                end
                OP_SEND_MID: begin
                    if (can_send) begin
                        pc <= pc + 3'd1;
                    end
                end
                OP_JUMP: begin
                    pc <= '0;
                end
                default: begin
                    pc <= pc + 3'd1;
                end
            endcase
        end
    end

    // Strobes outside OP_WAIT_IN are dropped
    assign accept   = sample_in_rdy && (op == OP_WAIT_IN);
    assign send_mid = (op == OP_SEND_MID) && can_send;

endmodule

`default_nettype wire

// File: hdl/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
    parameter int DEPTH = 2
) (
    input  logic                          reset,
    input  logic                          clk,
    input  logic                          wr,
    input  logic                          rd,
    input  dac_types_pkg::stereo_t        data_in,
    output dac_types_pkg::stereo_t        data_out,
    output logic                          empty,
    output logic                          full,
    output logic [$clog2(DEPTH+1)-1:0]    free_count
);
    import dac_types_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    stereo_t         mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_wr;
    logic            do_rd;

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
            end
            if (do_wr && !do_rd) begin
                count <= count + CW'(1);
            end else if (do_rd && !do_wr) begin
                count <= count - CW'(1);
            end
        end
    end

    always_ff @(posedge reset) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Show-ahead head
    assign data_out   = mem[rd_ptr];
    assign empty      = (count == '0);
    assign full       = (count == CW'(DEPTH));
    assign free_count = CW'(DEPTH) - count;

endmodule

`default_nettype wire

// File: hdl/sigma_delta_2nd.sv
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_2nd (
    input  logic                   reset,
    input  logic                   clk,
    input  logic                   fifo_empty,
    input  dac_types_pkg::stereo_t fifo_data,
    output logic                   fifo_rd,
    output logic                   dout_l,
    output logic                   dout_r
);
    import dac_types_pkg::*;
    import dac_timing_pkg::*;

    div_cnt_t   div_cnt;
    logic       running;
    stereo_t    held;
    acc_t       x_in     [2];
    acc_t       fb       [2];
    acc_t       integ1   [2];
    acc_t       integ2   [2];
    acc_t       integ1_n [2];
    acc_t       integ2_n [2];
    logic [1:0] bit_q;

    // ------------------------------------------------------------
    // Sample pacing
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            div_cnt <= '0;
            fifo_rd <= 1'b0;
            running <= 1'b0;
            held    <= '0;
        end else begin
            if (div_cnt == div_cnt_t'(CLK_DIV_OUT - 1)) begin
                div_cnt <= '0;
                // Keep the old sample on underrun
                fifo_rd <= !fifo_empty;
            end else begin
                div_cnt <= div_cnt + div_cnt_t'(1);
                fifo_rd <= 1'b0;
            end
            if (fifo_rd) begin
                held    <= fifo_data;
                running <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Second-order loop with index 0 for left and 1 for right
    // ------------------------------------------------------------
    always_comb begin
        x_in[0] = acc_t'(held.l);
        x_in[1] = acc_t'(held.r);
        for (int ch = 0; ch < 2; ch++) begin
            fb[ch]       = (integ2[ch] < 0) ? -SD_FULL_SCALE : SD_FULL_SCALE;
            integ1_n[ch] = integ1[ch] + x_in[ch] - fb[ch];
            integ2_n[ch] = integ2[ch] + integ1_n[ch] - fb[ch];
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int ch = 0; ch < 2; ch++) begin
                integ1[ch] <= '0;
                integ2[ch] <= '0;
            end
            bit_q <= '0;
        end else if (running) begin
            for (int ch = 0; ch < 2; ch++) begin
                integ1[ch] <= integ1_n[ch];
                integ2[ch] <= integ2_n[ch];
                bit_q[ch]  <= (integ2_n[ch] >= 0);
            end
        end
    end

    assign dout_l = bit_q[0];
    assign dout_r = bit_q[1];

endmodule

`default_nettype wire

// File: hdl/stereo_dac_output.sv
`timescale 1ns/1ps
`default_nettype none

module stereo_dac_output (
    input  logic                   reset,
    input  logic                   clk,
    input  logic                   sample_in_rdy,
    input  dac_types_pkg::stereo_t sample_in,
    output logic                   dout_l,
    output logic                   dout_r
);
    import dac_types_pkg::*;
    import dac_timing_pkg::*;

    logic      accept;
    logic      send_mid;
    logic      stage_done;

    logic      s1_rdy;
    stereo_t   s1_data;
    logic      s1_done;

    stereo_t   mid_head;

    logic      s2_rdy;
    stereo_t   s2_data;
    logic      s2_done;

    stereo_t   out_head;
    logic      out_empty;
    out_free_t out_free;
    logic      sd_rd;

    // Only one stage is busy at a time
    assign stage_done = s1_done | s2_done;

    // ------------------------------------------------------------
    // Interpolation, 2x then 2x
    // ------------------------------------------------------------
    interp_halfband_2x u_stage1 (
        .reset          (reset),
        .clk            (clk),
        .sample_in_rdy  (accept),
        .sample_in      (sample_in),
        .sample_out_rdy (s1_rdy),
        .sample_out     (s1_data),
        .done           (s1_done)
    );

    sample_fifo #(.DEPTH(FIFO_MID_DEPTH)) u_fifo_mid (
        .reset      (reset),
        .clk        (clk),
        .wr         (s1_rdy),
        .rd         (send_mid),
        .data_in    (s1_data),
        .data_out   (mid_head),
        .empty      (),
        .full       (),
        .free_count ()
    );

    interp_halfband_2x u_stage2 (
        .reset          (reset),
        .clk            (clk),
        .sample_in_rdy  (send_mid),
        .sample_in      (mid_head),
        .sample_out_rdy (s2_rdy),
        .sample_out     (s2_data),
        .done           (s2_done)
    );

    sample_fifo #(.DEPTH(FIFO_OUT_DEPTH)) u_fifo_out (
        .reset      (reset),
        .clk        (clk),
        .wr         (s2_rdy),
        .rd         (sd_rd),
        .data_in    (s2_data),
        .data_out   (out_head),
        .empty      (out_empty),
        .full       (),
        .free_count (out_free)
    );

    interp_sequencer u_sequencer (
        .reset         (reset),
        .clk           (clk),
        .sample_in_rdy (sample_in_rdy),
        .done          (stage_done),
        .out_free      (out_free),
        .accept        (accept),
        .send_mid      (send_mid)
    );

    // ------------------------------------------------------------
    // One-bit outputs
    // ------------------------------------------------------------
    sigma_delta_2nd u_modulator (
        .reset      (reset),
        .clk        (clk),
        .fifo_empty (out_empty),
        .fifo_data  (out_head),
        .fifo_rd    (sd_rd),
        .dout_l     (dout_l),
        .dout_r     (dout_r)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f all.f \
    --top-module tb_stereo_dac_output -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
